// File: common/fabric_defs.svh
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

// Grid size
`define FABRIC_MX 3
`define FABRIC_MY 4

// LUT inputs per tile
`define LUT_K 4

// Truth table plus register-select bit on top
`define TILE_CFG_W 17

// Register window, address bits 31:8 must match
`define CFG_BASE_ADDR 32'h3000_0000

// Register offsets inside the window
`define REG_CTRL   8'h00
`define REG_DATA   8'h04
`define REG_STATUS 8'h08
`define REG_ENABLE 8'h0C

`endif

// File: common/fabric_pkg.sv
`include "fabric_defs.svh"

package fabric_pkg;

// One tile's LUT inputs
typedef logic [`LUT_K-1:0] lut_in_t;

// Truth table, one bit per input combination
typedef logic [(1 << `LUT_K)-1:0] lut_tt_t;

// Config word as shifted into a tile
typedef logic [`TILE_CFG_W-1:0] tile_cfg_t;

// Column select from CTRL
typedef logic [$clog2(`FABRIC_MX)-1:0] col_idx_t;

// One bit per column
typedef logic [`FABRIC_MX-1:0] col_mask_t;

endpackage

// File: common/wb_pkg.sv
package wb_pkg;

// Wishbone classic bus fields
typedef logic [31:0] wb_addr_t;
typedef logic [31:0] wb_data_t;
typedef logic [3:0]  wb_sel_t;

// Config shifter FSM
typedef enum logic [0:0] {
  SHIFT_IDLE = 1'b0,
  SHIFT_RUN  = 1'b1
} shift_state_t;

endpackage

// File: config/wb_config_regs.sv
`timescale 1ns/100ps
`include "fabric_defs.svh"

module wb_config_regs (
  input  logic                  wb_clk_i,
  input  logic                  arst_n_i,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_we_i,
  input  wb_pkg::wb_sel_t       wbs_sel_i,
  input  wb_pkg::wb_addr_t      wbs_addr_i,
  input  wb_pkg::wb_data_t      wbs_data_i,
  input  logic                  busy_i,
  output logic                  wbs_ack_o,
  output wb_pkg::wb_data_t      wbs_data_o,
  output logic                  load_o,
  output fabric_pkg::col_idx_t  load_col_o,
  output fabric_pkg::tile_cfg_t cfg_word_o,
  output fabric_pkg::col_mask_t col_en_o
);

localparam wb_pkg::wb_addr_t BASE_ADDR = `CFG_BASE_ADDR;

logic                  hit;
logic                  req;
logic [7:0]            offset;
wb_pkg::wb_data_t      wmask;
wb_pkg::wb_data_t      rd_data;
fabric_pkg::col_idx_t  ctrl_col_q;
fabric_pkg::tile_cfg_t data_q;
fabric_pkg::col_mask_t enable_q;
logic                  overrun_q;

// Keep the old bits where the byte lane is not selected
function automatic wb_pkg::wb_data_t merge_bytes(
  input wb_pkg::wb_data_t old_v,
  input wb_pkg::wb_data_t new_v,
  input wb_pkg::wb_data_t mask
);
  return (old_v & ~mask) | (new_v & mask);
endfunction

assign hit    = (wbs_addr_i[31:8] == BASE_ADDR[31:8]);
assign offset = wbs_addr_i[7:0];

// New request only outside the ack cycle
assign req = wbs_cyc_i && wbs_stb_i && hit && !wbs_ack_o;

always_comb begin
  for (int b = 0; b < 4; b++) begin
    wmask[8*b +: 8] = {8{wbs_sel_i[b]}};
  end
end

always_comb begin
  case (offset)
    `REG_CTRL:   rd_data = wb_pkg::wb_data_t'(ctrl_col_q);
    `REG_DATA:   rd_data = wb_pkg::wb_data_t'(data_q);
    `REG_STATUS: rd_data = {7'b0, data_q, 6'b0, overrun_q, busy_i};
    `REG_ENABLE: rd_data = wb_pkg::wb_data_t'(enable_q);
    default:     rd_data = '0;
  endcase
end

always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
  if (!arst_n_i) begin
    wbs_ack_o  <= 1'b0;
    wbs_data_o <= '0;
    load_o     <= 1'b0;
    ctrl_col_q <= '0;
    data_q     <= '0;
    enable_q   <= '0;
    overrun_q  <= 1'b0;
  end else begin
    wbs_ack_o <= req;
    load_o    <= 1'b0;
    if (req && !wbs_we_i) begin
      wbs_data_o <= rd_data;
    end
    if (req && wbs_we_i) begin
      case (offset)
        `REG_CTRL: begin
          ctrl_col_q <= fabric_pkg::col_idx_t'(merge_bytes(
            wb_pkg::wb_data_t'(ctrl_col_q), wbs_data_i, wmask));
        end
        `REG_DATA: begin
          // Shifter still running, drop the word
          if (busy_i) begin
            overrun_q <= 1'b1;
          end else begin
            data_q <= fabric_pkg::tile_cfg_t'(merge_bytes(
              wb_pkg::wb_data_t'(data_q), wbs_data_i, wmask));
            load_o <= 1'b1;
          end
        end
        `REG_STATUS: begin
          if (wmask[1] && wbs_data_i[1]) begin
            overrun_q <= 1'b0;
          end
        end
        `REG_ENABLE: begin
          enable_q <= fabric_pkg::col_mask_t'(merge_bytes(
            wb_pkg::wb_data_t'(enable_q), wbs_data_i, wmask));
        end
        default: ;
      endcase
    end
  end
end

// CTRL cannot change during the ack cycle, so it travels with load
assign load_col_o = ctrl_col_q;
assign cfg_word_o = data_q;
assign col_en_o   = enable_q;

a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
  wbs_ack_o |=> !wbs_ack_o)
  else $error("wb_config_regs: ack held for two cycles");

endmodule

// File: config/config_shifter.sv
`timescale 1ns/100ps
`include "fabric_defs.svh"

module config_shifter (
  input  logic                  wb_clk_i,
  input  logic                  arst_n_i,
  input  logic                  load_i,
  input  fabric_pkg::col_idx_t  load_col_i,
  input  fabric_pkg::tile_cfg_t cfg_word_i,
  output logic                  busy_o,
  output logic                  cfg_bit_o,
  output fabric_pkg::col_mask_t shift_en_o
);

// Count of the final bit of a word
localparam logic [4:0] LAST_BIT = 5'(`TILE_CFG_W - 1);

wb_pkg::shift_state_t  state_q;
fabric_pkg::tile_cfg_t word_q;
fabric_pkg::col_idx_t  col_q;
logic [4:0]            cnt_q;

always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
  if (!arst_n_i) begin
    state_q <= wb_pkg::SHIFT_IDLE;
    word_q  <= '0;
    col_q   <= '0;
    cnt_q   <= '0;
  end else begin
    case (state_q)
      wb_pkg::SHIFT_IDLE: begin
        if (load_i) begin
          word_q  <= cfg_word_i;
          col_q   <= load_col_i;
          cnt_q   <= '0;
          state_q <= wb_pkg::SHIFT_RUN;
        end
      end
      wb_pkg::SHIFT_RUN: begin
        // LSB goes out first
        word_q <= word_q >> 1;
        cnt_q  <= cnt_q + 5'd1;
        if (cnt_q == LAST_BIT) begin
          state_q <= wb_pkg::SHIFT_IDLE;
        end
      end
      default: state_q <= wb_pkg::SHIFT_IDLE;
    endcase
  end
end

assign busy_o    = (state_q == wb_pkg::SHIFT_RUN);
assign cfg_bit_o = word_q[0];

// Only the latched column sees shift pulses
always_comb begin
  for (int c = 0; c < `FABRIC_MX; c++) begin
    shift_en_o[c] = busy_o && (col_q == fabric_pkg::col_idx_t'(c));
  end
end

a_no_load_busy: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
  load_i |-> !busy_o)
  else $error("config_shifter: load arrived while busy");

a_shift_onehot: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
  $onehot0(shift_en_o))
  else $error("config_shifter: shift_en not one-hot, %h", shift_en_o);

endmodule

// File: clb/clb_tile.sv
`timescale 1ns/100ps
`include "fabric_defs.svh"

module clb_tile (
  input  logic                wb_clk_i,
  input  logic                arst_n_i,
  input  logic                shift_en_i,
  input  logic                cfg_bit_i,
  output logic                cfg_bit_o,
  input  logic                en_i,
  input  fabric_pkg::lut_in_t lut_in_i,
  output logic                out_o
);

fabric_pkg::tile_cfg_t cfg_q;
fabric_pkg::lut_tt_t   truth_tbl;
logic                  reg_sel;
logic                  lut_out;
logic                  out_q;

// Config chain, new bits enter at the top
always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
  if (!arst_n_i) begin
    cfg_q <= '0;
  end else if (shift_en_i) begin
    cfg_q <= {cfg_bit_i, cfg_q[`TILE_CFG_W-1:1]};
  end
end

// Bit 0 falls through to the next tile
assign cfg_bit_o = cfg_q[0];

assign truth_tbl = cfg_q[(1 << `LUT_K)-1:0];
assign reg_sel   = cfg_q[`TILE_CFG_W-1];

// LUT lookup
assign lut_out = truth_tbl[lut_in_i];

// Output flop, gated by the column enable
always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
  if (!arst_n_i) begin
    out_q <= 1'b0;
  end else if (en_i) begin
    out_q <= lut_out;
  end
end

assign out_o = reg_sel ? out_q : lut_out;

endmodule

// File: clb/clb_column.sv
`timescale 1ns/100ps
`include "fabric_defs.svh"

module clb_column #(
  parameter int MY = 4
) (
  input  logic                wb_clk_i,
  input  logic                arst_n_i,
  input  logic                shift_en_i,
  input  logic                cfg_bit_i,
  input  logic                en_i,
  input  fabric_pkg::lut_in_t gpio_i,
  output logic                out_o
);

// Serial config links from the column input at entry 0 to the last tile's output
logic [MY:0]   cfg_chain;
// Tile outputs that feed input 3 of the next tile
logic [MY-1:0] out_chain;

assign cfg_chain[0] = cfg_bit_i;

for (genvar k = 0; k < MY; k++) begin : g_tile
  fabric_pkg::lut_in_t tile_in;

  if (k == 0) begin : g_first
    assign tile_in = gpio_i;
  end else begin : g_rest
    assign tile_in = {out_chain[k-1], gpio_i[`LUT_K-2:0]};
  end

  clb_tile u_tile (
    .wb_clk_i   (wb_clk_i),
    .arst_n_i   (arst_n_i),
    .shift_en_i (shift_en_i),
    .cfg_bit_i  (cfg_chain[k]),
    .cfg_bit_o  (cfg_chain[k+1]),
    .en_i       (en_i),
    .lut_in_i   (tile_in),
    .out_o      (out_chain[k])
  );
end

assign out_o = out_chain[MY-1];

endmodule

// File: source/fabric_top.sv
`timescale 1ns/100ps
`include "fabric_defs.svh"

module fabric_top (
  input  logic                         wb_clk_i,
  input  logic                         arst_n_i,

  // Wishbone slave
  input  logic                         wbs_cyc_i,
  input  logic                         wbs_stb_i,
  input  logic                         wbs_we_i,
  input  wb_pkg::wb_sel_t              wbs_sel_i,
  input  wb_pkg::wb_addr_t             wbs_addr_i,
  input  wb_pkg::wb_data_t             wbs_data_i,
  output logic                         wbs_ack_o,
  output wb_pkg::wb_data_t             wbs_data_o,

  // Fabric pins
  input  logic [`FABRIC_MX*`LUT_K-1:0] gpio_in_i,
  output logic [`FABRIC_MX-1:0]        gpio_out_o
);

logic                  load;
fabric_pkg::col_idx_t  load_col;
fabric_pkg::tile_cfg_t cfg_word;
fabric_pkg::col_mask_t col_en;
logic                  busy;
logic                  cfg_bit;
fabric_pkg::col_mask_t shift_en;

wb_config_regs u_regs (
  .wb_clk_i   (wb_clk_i),
  .arst_n_i   (arst_n_i),
  .wbs_cyc_i  (wbs_cyc_i),
  .wbs_stb_i  (wbs_stb_i),
  .wbs_we_i   (wbs_we_i),
  .wbs_sel_i  (wbs_sel_i),
  .wbs_addr_i (wbs_addr_i),
  .wbs_data_i (wbs_data_i),
  .busy_i     (busy),
  .wbs_ack_o  (wbs_ack_o),
  .wbs_data_o (wbs_data_o),
  .load_o     (load),
  .load_col_o (load_col),
  .cfg_word_o (cfg_word),
  .col_en_o   (col_en)
);

config_shifter u_shifter (
  .wb_clk_i   (wb_clk_i),
  .arst_n_i   (arst_n_i),
  .load_i     (load),
  .load_col_i (load_col),
  .cfg_word_i (cfg_word),
  .busy_o     (busy),
  .cfg_bit_o  (cfg_bit),
  .shift_en_o (shift_en)
);

// All columns share the serial bit, shift_en picks the target
for (genvar c = 0; c < `FABRIC_MX; c++) begin : g_col
  clb_column #(
    .MY(`FABRIC_MY)
  ) u_col (
    .wb_clk_i   (wb_clk_i),
    .arst_n_i   (arst_n_i),
    .shift_en_i (shift_en[c]),
    .cfg_bit_i  (cfg_bit),
    .en_i       (col_en[c]),
    .gpio_i     (gpio_in_i[c*`LUT_K +: `LUT_K]),
    .out_o      (gpio_out_o[c])
  );
end

endmodule

// File: test/tb_fabric_top.sv
`timescale 1ns/100ps
`include "fabric_defs.svh"

module tb_fabric_top;

localparam int RUN_LEN     = 48;
// Two full loads of the grid plus the overrun pair
localparam int CFG_WORDS   = 2 * `FABRIC_MX * `FABRIC_MY + 2;
localparam int CYCLE_LIMIT = 16 + CFG_WORDS * 32 + 7 * RUN_LEN + 320;

logic                         wb_clk = 1'b0;
logic                         arst_n;
logic                         wbs_cyc, wbs_stb, wbs_we, wbs_ack;
wb_pkg::wb_sel_t              wbs_sel;
wb_pkg::wb_addr_t             wbs_addr;
wb_pkg::wb_data_t             wbs_data, wbs_rdata, rd_word;
logic [`FABRIC_MX*`LUT_K-1:0] gpio_in;
logic [`FABRIC_MX-1:0]        gpio_out;

int          value_errs = 0;
int          proto_errs = 0;
int          cycle_cnt  = 0;
logic [31:0] rng_state  = 32'hb3dc;
logic        check_en, hold_chk;

// Reference model of the grid
fabric_pkg::tile_cfg_t                 model_cfg [`FABRIC_MX][`FABRIC_MY];
fabric_pkg::col_mask_t                 en_model;
logic [`FABRIC_MX-1:0][`FABRIC_MY-1:0] model_lut, model_q;
logic [`FABRIC_MX-1:0]                 exp_out;

always #4 wb_clk = ~wb_clk;

fabric_top dut0 (
  .wb_clk_i   (wb_clk),
  .arst_n_i   (arst_n),
  .wbs_cyc_i  (wbs_cyc),
  .wbs_stb_i  (wbs_stb),
  .wbs_we_i   (wbs_we),
  .wbs_sel_i  (wbs_sel),
  .wbs_addr_i (wbs_addr),
  .wbs_data_i (wbs_data),
  .wbs_ack_o  (wbs_ack),
  .wbs_data_o (wbs_rdata),
  .gpio_in_i  (gpio_in),
  .gpio_out_o (gpio_out)
);

// Chain rule, tile k>0 takes the tile below as input 3
always_comb begin
  fabric_pkg::lut_in_t idx;
  fabric_pkg::lut_tt_t tt;
  logic                lut_v;
  logic                chain_v;
  chain_v = 1'b0;
  for (int c = 0; c < `FABRIC_MX; c++) begin
    for (int k = 0; k < `FABRIC_MY; k++) begin
      if (k == 0) begin
        idx = gpio_in[c*`LUT_K +: `LUT_K];
      end else begin
        idx = {chain_v, gpio_in[c*`LUT_K +: `LUT_K-1]};
      end
      tt              = model_cfg[c][k][(1 << `LUT_K)-1:0];
      lut_v           = tt[idx];
      model_lut[c][k] = lut_v;
      chain_v         = model_cfg[c][k][`TILE_CFG_W-1] ? model_q[c][k] : lut_v;
    end
    exp_out[c] = chain_v;
  end
end

always_ff @(posedge wb_clk or negedge arst_n) begin
  if (!arst_n) begin
    model_q <= '0;
  end else begin
    for (int c = 0; c < `FABRIC_MX; c++) begin
      for (int k = 0; k < `FABRIC_MY; k++) begin
        if (en_model[c]) model_q[c][k] <= model_lut[c][k];
      end
    end
  end
end

a_out_match: assert property (@(posedge wb_clk) disable iff (!arst_n || !check_en)
  gpio_out == exp_out)
  else begin
    value_errs = value_errs + 1;
    $display("error gpio_out_o got %h expected %h", $sampled(gpio_out), $sampled(exp_out));
  end

// All tiles registered, so nothing may move with ENABLE cleared
a_out_hold: assert property (@(posedge wb_clk) disable iff (!arst_n || !hold_chk)
  (en_model == '0) |=> $stable(gpio_out))
  else begin
    value_errs = value_errs + 1;
    $display("error gpio_out_o changed to %h with ENABLE at 0", $sampled(gpio_out));
  end

always @(posedge wb_clk) begin
  cycle_cnt = cycle_cnt + 1;
  if (cycle_cnt > CYCLE_LIMIT) begin
    $display("run stopped, no result after %0d cycles", cycle_cnt);
    $display(">>> FAIL");
    $finish;
  end
end

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  return y ^ (y << 5);
endfunction

function automatic wb_pkg::wb_addr_t reg_addr(input logic [7:0] off);
  wb_pkg::wb_addr_t base;
  base = `CFG_BASE_ADDR;
  return {base[31:8], off};
endfunction

task automatic next_rand(output logic [31:0] r);
  rng_state = xorshift32(rng_state);
  r = rng_state;
endtask

// One Wishbone classic cycle, read data lands in rd_word
task automatic bus_cycle(input wb_pkg::wb_addr_t addr, input logic we,
                         input wb_pkg::wb_data_t data, input wb_pkg::wb_sel_t sel);
  int waited;
  waited = 0;
  @(negedge wb_clk);
  wbs_cyc  = 1'b1;
  wbs_stb  = 1'b1;
  wbs_we   = we;
  wbs_addr = addr;
  wbs_data = data;
  wbs_sel  = sel;
  @(negedge wb_clk);
  while (!wbs_ack && waited < 8) begin
    @(negedge wb_clk);
    waited++;
  end
  assert (wbs_ack) else begin
    proto_errs = proto_errs + 1;
    $display("bus cycle at address %h was never acknowledged", addr);
  end
  rd_word = wbs_rdata;
  wbs_cyc = 1'b0;
  wbs_stb = 1'b0;
  wbs_we  = 1'b0;
endtask

task automatic check_reg(input logic [7:0] off, input wb_pkg::wb_data_t exp, input string name);
  bus_cycle(reg_addr(off), 1'b0, '0, 4'hF);
  assert (rd_word === exp) else begin
    value_errs = value_errs + 1;
    $display("error wbs_data_o %s got %h expected %h", name, rd_word, exp);
  end
endtask

task automatic probe_no_ack(input wb_pkg::wb_addr_t addr);
  logic seen;
  seen = 1'b0;
  @(negedge wb_clk);
  wbs_cyc  = 1'b1;
  wbs_stb  = 1'b1;
  wbs_we   = 1'b0;
  wbs_addr = addr;
  repeat (4) begin
    @(negedge wb_clk);
    if (wbs_ack) seen = 1'b1;
  end
  wbs_cyc = 1'b0;
  wbs_stb = 1'b0;
  assert (!seen) else begin
    proto_errs = proto_errs + 1;
    $display("address %h outside the window was acknowledged", addr);
  end
endtask

task automatic wait_idle();
  int tries;
  tries   = 0;
  rd_word = 32'h1;
  while (rd_word[0] && tries < 30) begin
    bus_cycle(reg_addr(`REG_STATUS), 1'b0, '0, 4'hF);
    tries++;
  end
  assert (!rd_word[0]) else begin
    proto_errs = proto_errs + 1;
    $display("shifter still busy after %0d status reads", tries);
  end
endtask

// New word lands in tile 0, older words move up one tile
task automatic push_model_word(input int col, input fabric_pkg::tile_cfg_t word);
  for (int k = `FABRIC_MY - 1; k > 0; k--) begin
    model_cfg[col][k] = model_cfg[col][k-1];
  end
  model_cfg[col][0] = word;
endtask

task automatic load_column(input int col, input logic reg_bit);
  logic [31:0]           r;
  fabric_pkg::tile_cfg_t word;
  bus_cycle(reg_addr(`REG_CTRL), 1'b1, 32'(col), 4'hF);
  for (int i = 0; i < `FABRIC_MY; i++) begin
    next_rand(r);
    word = {reg_bit, r[15:0]};
    bus_cycle(reg_addr(`REG_DATA), 1'b1, 32'(word), 4'hF);
    wait_idle();
    push_model_word(col, word);
  end
endtask

task automatic set_enable(input wb_pkg::wb_data_t data, input wb_pkg::wb_sel_t sel);
  bus_cycle(reg_addr(`REG_ENABLE), 1'b1, data, sel);
  if (sel[0]) en_model = data[`FABRIC_MX-1:0];
endtask

task automatic run_gpio(input int n);
  logic [31:0] r;
  repeat (n) begin
    @(negedge wb_clk);
    next_rand(r);
    gpio_in = r[`FABRIC_MX*`LUT_K-1:0];
  end
endtask

initial begin
  logic [31:0]           r;
  fabric_pkg::tile_cfg_t w1;
  arst_n   = 1'b0;
  wbs_cyc  = 1'b0;
  wbs_stb  = 1'b0;
  wbs_we   = 1'b0;
  wbs_sel  = '0;
  wbs_addr = '0;
  wbs_data = '0;
  gpio_in  = '0;
  rd_word  = '0;
  check_en = 1'b0;
  hold_chk = 1'b0;
  en_model = '0;
  for (int c = 0; c < `FABRIC_MX; c++) begin
    for (int k = 0; k < `FABRIC_MY; k++) model_cfg[c][k] = '0;
  end
  repeat (16) @(posedge wb_clk);
  @(negedge wb_clk);
  arst_n   = 1'b1;
  check_en = 1'b1;

  // Everything idle and zero out of reset
  assert (wbs_ack === 1'b0) else begin
    value_errs = value_errs + 1;
    $display("error wbs_ack_o got %h expected 0", wbs_ack);
  end
  check_reg(`REG_CTRL, 32'h0, "CTRL");
  check_reg(`REG_DATA, 32'h0, "DATA");
  check_reg(`REG_STATUS, 32'h0, "STATUS");
  check_reg(`REG_ENABLE, 32'h0, "ENABLE");
  check_reg(8'h10, 32'h0, "unmapped");

  // Byte lanes, only byte 0 carries CTRL and ENABLE bits
  bus_cycle(reg_addr(`REG_CTRL), 1'b1, 32'h0000_0102, 4'b0010);
  check_reg(`REG_CTRL, 32'h0, "CTRL upper lanes");
  bus_cycle(reg_addr(`REG_CTRL), 1'b1, 32'hFFFF_FF02, 4'b0001);
  check_reg(`REG_CTRL, 32'h2, "CTRL lane 0");
  set_enable(32'h0000_0705, 4'b1110);
  check_reg(`REG_ENABLE, 32'h0, "ENABLE upper lanes");
  set_enable(32'hFFFF_FF05, 4'b0001);
  check_reg(`REG_ENABLE, 32'h5, "ENABLE lane 0");
  set_enable(32'h0, 4'hF);
  probe_no_ack(32'h3000_0100);
  probe_no_ack(32'h2000_0004);

  // Combinational columns
  check_en = 1'b0;
  for (int c = 0; c < `FABRIC_MX; c++) load_column(c, 1'b0);
  check_en = 1'b1;
  run_gpio(RUN_LEN);

  // Registered columns under changing enables
  check_en = 1'b0;
  for (int c = 0; c < `FABRIC_MX; c++) load_column(c, 1'b1);
  check_en = 1'b1;
  hold_chk = 1'b1;
  run_gpio(RUN_LEN);
  set_enable(32'h5, 4'hF);
  run_gpio(RUN_LEN);
  set_enable(32'h2, 4'hF);
  run_gpio(RUN_LEN);
  set_enable(32'h7, 4'hF);
  run_gpio(RUN_LEN);
  set_enable(32'h0, 4'hF);
  run_gpio(RUN_LEN);
  hold_chk = 1'b0;

  // Second word arrives while the first is still shifting
  check_en = 1'b0;
  next_rand(r);
  w1 = {1'b0, r[15:0]};
  bus_cycle(reg_addr(`REG_CTRL), 1'b1, 32'h0, 4'hF);
  bus_cycle(reg_addr(`REG_DATA), 1'b1, 32'(w1), 4'hF);
  bus_cycle(reg_addr(`REG_DATA), 1'b1, 32'(~w1), 4'hF);
  wait_idle();
  push_model_word(0, w1);
  check_reg(`REG_STATUS, {7'b0, w1, 6'b0, 2'b10}, "STATUS overrun");
  bus_cycle(reg_addr(`REG_STATUS), 1'b1, 32'h2, 4'hF);
  check_reg(`REG_STATUS, {7'b0, w1, 8'b0}, "STATUS cleared");
  set_enable(32'h7, 4'hF);
  check_en = 1'b1;
  run_gpio(RUN_LEN);

  @(negedge wb_clk);
  $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
  if (value_errs == 0 && proto_errs == 0) begin
    $display(">>> PASS");
  end else begin
    $display(">>> FAIL");
  end
  $finish;
end

endmodule

// File: all.f
+incdir+common
common/fabric_pkg.sv
common/wb_pkg.sv
config/wb_config_regs.sv
config/config_shifter.sv
clb/clb_tile.sv
clb/clb_column.sv
source/fabric_top.sv
test/tb_fabric_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_fabric_top
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "simulation gave no result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
